/* tb.f */
+incdir+include
source/cacheCtlPkg.sv
source/reqIf.sv
source/reqDecode.sv
source/fillSequencer.sv
source/cmdDrive.sv
source/cacheCtlTop.sv
sim/tbClock.sv
sim/cacheCtlTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the exit status is the simulator's, non-zero on any failure
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f tb.f --top-module cacheCtlTb -Mdir obj_dir &&
./obj_dir/VcacheCtlTb || exit 1

/* sim/cacheCtlTb.sv */
module cacheCtlTb;
   timeunit 1ns;
   timeprecision 1ps;

   // reset plus all five tests take about 60 cycles
   localparam int timeoutCycles = 200;

   logic clk;
   logic arstN;

   // processor side
   logic              rd;
   logic              wr;
   logic              stall;
   cacheCtlPkg::addrT addr;
   cacheCtlPkg::dataT dataIn;

   // way status set per test
   logic             hitC0;
   logic             hitC1;
   logic             validC0;
   logic             validC1;
   logic             dirtyC0;
   logic             dirtyC1;
   logic             victimWay;
   cacheCtlPkg::tagT tagC0;
   cacheCtlPkg::tagT tagC1;

   // data arrays and memory
   cacheCtlPkg::dataT cacheDataOut;
   cacheCtlPkg::dataT memDataOut;

   // DUT outputs
   cacheCtlPkg::dataT    fsmDataOut;
   cacheCtlPkg::addrT    addrOut;
   cacheCtlPkg::wordIdxT wordOut;
   logic                 done;
   logic                 stallOut;
   logic                 cacheWrite0;
   logic                 cacheWrite1;
   logic                 memWrite;
   logic                 memRead;
   logic                 comp0;
   logic                 comp1;
   logic                 enC0;
   logic                 enC1;

   // memory read in flight one stage before its data comes back
   logic              memPipeValid;
   cacheCtlPkg::addrT memPipeAddr;

   // per test offset of the cache line contents
   cacheCtlPkg::dataT cacheBase;

   logic [31:0] lcgState;
   int          cycleCount = 0;
   string       testName;

   tbClock tbClock_i (
      .clk   (clk),
      .arstN (arstN)
   );

   cacheCtlTop dut_i (
      .clk          (clk),
      .arstN        (arstN),
      .rd           (rd),
      .wr           (wr),
      .stall        (stall),
      .addr         (addr),
      .dataIn       (dataIn),
      .hitC0        (hitC0),
      .hitC1        (hitC1),
      .validC0      (validC0),
      .validC1      (validC1),
      .dirtyC0      (dirtyC0),
      .dirtyC1      (dirtyC1),
      .victimWay    (victimWay),
      .tagC0        (tagC0),
      .tagC1        (tagC1),
      .cacheDataOut (cacheDataOut),
      .memDataOut   (memDataOut),
      .fsmDataOut   (fsmDataOut),
      .addrOut      (addrOut),
      .wordOut      (wordOut),
      .done         (done),
      .stallOut     (stallOut),
      .cacheWrite0  (cacheWrite0),
      .cacheWrite1  (cacheWrite1),
      .memWrite     (memWrite),
      .memRead      (memRead),
      .comp0        (comp0),
      .comp1        (comp1),
      .enC0         (enC0),
      .enC1         (enC1)
   );

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // memory word built from every bit of the byte address
   function automatic cacheCtlPkg::dataT memPattern(input cacheCtlPkg::addrT a);
      return {a[7:0], a[15:8]} ^ 16'hc3a5;
   endfunction

   // cache line word as the data array returns it
   function automatic cacheCtlPkg::dataT cacheWordOf(input cacheCtlPkg::dataT base,
                                                     input cacheCtlPkg::wordIdxT idx);
      return base + (16'h1111 * {14'b0, idx});
   endfunction

   // upper half of the generator state is the better mixed one
   task automatic drawRandom(output logic [15:0] v);
      lcgState = lcgNext(lcgState);
      v = lcgState[31:16];
   endtask

   task automatic stopOnError(input string reason);
      $display("%s", reason);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic expectEq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         stopOnError($sformatf("FAILED %s %s expected %h actual %h",
                               testName, what, expected, actual));
      end
   endtask

   // data array follows the word the controller asks for
   assign cacheDataOut = cacheWordOf(cacheBase, wordOut);

   // reads come back two cycles after memRead
   always @(posedge clk)
   begin
      memPipeValid <= memRead;
      memPipeAddr  <= addrOut;
      memDataOut   <= memPipeValid ? memPattern(memPipeAddr) : '0;
   end

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles)
      begin
         stopOnError("timeout, the tests did not finish within the cycle limit");
      end
   end

   // banks are either read or written and never both
   assert property (@(posedge clk) disable iff (!arstN) !(memRead && memWrite))
   else stopOnError("memory read and memory write were raised in the same cycle");

   assert property (@(posedge clk) disable iff (!arstN) !(cacheWrite0 && cacheWrite1))
   else stopOnError("both ways were written in the same cycle");

   // a way is only written while it is enabled
   assert property (@(posedge clk) disable iff (!arstN) cacheWrite0 |-> enC0)
   else stopOnError("way 0 was written without its enable");

   assert property (@(posedge clk) disable iff (!arstN) cacheWrite1 |-> enC1)
   else stopOnError("way 1 was written without its enable");

   // memory traffic only inside a miss sequence
   assert property (@(posedge clk) disable iff (!arstN) (memRead || memWrite) |-> stallOut)
   else stopOnError("memory command issued while the processor was not stalled");

   // new way status and cache contents set one idle cycle before the request
   task automatic setWays(input logic h0, input logic h1, input logic v0, input logic v1,
                          input logic d0, input logic d1, input logic victim,
                          input cacheCtlPkg::tagT t0, input cacheCtlPkg::tagT t1);
      logic [15:0] noise;
      @(posedge clk);
      drawRandom(noise);
      hitC0     <= h0;
      hitC1     <= h1;
      validC0   <= v0;
      validC1   <= v1;
      dirtyC0   <= d0;
      dirtyC1   <= d1;
      victimWay <= victim;
      tagC0     <= t0;
      tagC1     <= t1;
      cacheBase <= noise;
   endtask

   // drives the request cycle and returns mid cycle where outputs are settled
   task automatic issueRequest(input logic r, input logic w, input logic s,
                               input cacheCtlPkg::addrT a, input cacheCtlPkg::dataT d);
      @(posedge clk);
      rd     <= r;
      wr     <= w;
      stall  <= s;
      addr   <= a;
      dataIn <= d;
      @(negedge clk);
   endtask

   // with the inputs released the controller must be idle and quiet
   task automatic endRequest();
      @(posedge clk);
      rd    <= 1'b0;
      wr    <= 1'b0;
      stall <= 1'b0;
      @(negedge clk);
      expectEq("stallOut when idle", 0, stallOut);
      expectEq("done when idle", 0, done);
   endtask

   // cycle by cycle schedule of a miss after the request cycle
   task automatic followMiss(input logic dirty, input logic way, input logic isWrite,
                             input cacheCtlPkg::addrT a, input cacheCtlPkg::dataT d,
                             input cacheCtlPkg::tagT victimTag, input logic scramble);
      int                wb;
      int                f;
      logic              expCw;
      logic [15:0]       noise;
      cacheCtlPkg::addrT lineBase;
      cacheCtlPkg::addrT victimBase;
      wb = dirty ? 4 : 0;
      // tag 15..11, index 10..3, word 2..1, byte bit 0
      lineBase   = {a[15:3], 3'b000};
      victimBase = {victimTag, a[10:3], 3'b000};
      for (int k = 1; k <= wb + 8; k++)
      begin
         @(posedge clk);
         if (scramble)
         begin
            // everything on the processor side moves and none of it may matter
            drawRandom(noise);
            rd    <= noise[0];
            wr    <= noise[1];
            stall <= noise[2];
            addr  <= {noise[15:1], 1'b0};
            drawRandom(noise);
            dataIn <= noise;
         end
         else
         begin
            rd <= 1'b0;
            wr <= 1'b0;
         end
         @(negedge clk);
         f = k - wb;
         expCw = (f >= 3 && f <= 6) || (f == 7 && isWrite);
         expectEq("stallOut", 1, stallOut);
         expectEq("done", k == wb + 8, done);
         expectEq("memWrite", k <= wb, memWrite);
         expectEq("memRead", f >= 1 && f <= 4, memRead);
         expectEq("cacheWrite0", expCw && !way, cacheWrite0);
         expectEq("cacheWrite1", expCw && way, cacheWrite1);
         if (k <= wb)
         begin
            // victim word k-1 goes out under the old tag
            expectEq("writeback addrOut", victimBase + 16'(2 * (k - 1)), addrOut);
            expectEq("writeback wordOut", k - 1, wordOut);
            expectEq("writeback data", cacheWordOf(cacheBase, 2'(k - 1)), fsmDataOut);
         end
         if (f >= 1 && f <= 4)
         begin
            expectEq("fill addrOut", lineBase + 16'(2 * (f - 1)), addrOut);
         end
         if (f >= 3 && f <= 6)
         begin
            // data of the read two cycles back
            expectEq("fill wordOut", f - 3, wordOut);
            expectEq("fill data", memPattern(lineBase + 16'(2 * (f - 3))), fsmDataOut);
         end
         if (f == 7 && isWrite)
         begin
            expectEq("write data", d, fsmDataOut);
         end
         else if (f == 7)
         begin
            expectEq("read enable", 1, way ? enC1 : enC0);
            expectEq("read compare", 1, way ? comp1 : comp0);
         end
      end
      endRequest();
   endtask

   task automatic resetIdleTest();
      logic [15:0] a;
      logic [15:0] d;
      testName = "reset and idle";
      drawRandom(a);
      drawRandom(d);
      a[0] = 1'b0;
      setWays(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 5'h03, 5'h0c);
      @(negedge clk);
      expectEq("stallOut", 0, stallOut);
      expectEq("done", 0, done);
      expectEq("memRead", 0, memRead);
      expectEq("memWrite", 0, memWrite);
      expectEq("cacheWrite0", 0, cacheWrite0);
      expectEq("cacheWrite1", 0, cacheWrite1);
      // rd and wr together with a hit is still no request
      issueRequest(1'b1, 1'b1, 1'b0, a, d);
      expectEq("done with rd and wr", 0, done);
      endRequest();
      // a stalled hit must not complete
      issueRequest(1'b1, 1'b0, 1'b1, a, d);
      expectEq("done with stall", 0, done);
      endRequest();
      // neither kind of non-request may start a miss sequence
      setWays(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 5'h03, 5'h0c);
      issueRequest(1'b1, 1'b1, 1'b0, a, d);
      endRequest();
      issueRequest(1'b1, 1'b0, 1'b1, a, d);
      endRequest();
   endtask

   task automatic hitTest();
      logic [15:0] a;
      logic [15:0] d;
      testName = "read hit way 1";
      drawRandom(a);
      a[0] = 1'b0;
      setWays(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 5'h11, 5'h07);
      issueRequest(1'b1, 1'b0, 1'b0, a, '0);
      expectEq("done", 1, done);
      expectEq("enC1", 1, enC1);
      expectEq("comp1", 1, comp1);
      expectEq("stallOut", 0, stallOut);
      expectEq("memRead", 0, memRead);
      expectEq("memWrite", 0, memWrite);
      expectEq("cacheWrite1", 0, cacheWrite1);
      endRequest();
      testName = "write hit way 0";
      drawRandom(a);
      drawRandom(d);
      a[0] = 1'b0;
      setWays(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 5'h11, 5'h07);
      issueRequest(1'b0, 1'b1, 1'b0, a, d);
      expectEq("done", 1, done);
      expectEq("cacheWrite0", 1, cacheWrite0);
      expectEq("cacheWrite1", 0, cacheWrite1);
      expectEq("fsmDataOut", d, fsmDataOut);
      expectEq("stallOut", 0, stallOut);
      endRequest();
   endtask

   task automatic cleanMissTest();
      logic [15:0] a;
      testName = "clean read miss";
      drawRandom(a);
      a[0] = 1'b0;
      // way 1 is dirty but empty way 0 takes the line without a write-back
      setWays(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 5'h0a, 5'h15);
      issueRequest(1'b1, 1'b0, 1'b0, a, '0);
      expectEq("done in request cycle", 0, done);
      expectEq("stallOut in request cycle", 0, stallOut);
      followMiss(1'b0, 1'b0, 1'b0, a, '0, 5'h0a, 1'b0);
   endtask

   task automatic dirtyMissTest();
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] t;
      testName = "dirty write miss";
      drawRandom(a);
      drawRandom(d);
      drawRandom(t);
      a[0] = 1'b0;
      // way 0 holds the complement tag so the wrong victim tag always shows
      setWays(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, ~t[12:8], t[12:8]);
      issueRequest(1'b0, 1'b1, 1'b0, a, d);
      expectEq("done in request cycle", 0, done);
      followMiss(1'b1, 1'b1, 1'b1, a, d, t[12:8], 1'b0);
   endtask

   task automatic captureTest();
      logic [15:0] a;
      logic [15:0] d;
      testName = "capture";
      drawRandom(a);
      drawRandom(d);
      a[0] = 1'b0;
      // empty way 1 takes the line and dirty way 0 stays untouched
      setWays(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 5'h1f, 5'h01);
      issueRequest(1'b0, 1'b1, 1'b0, a, d);
      expectEq("done in request cycle", 0, done);
      followMiss(1'b0, 1'b1, 1'b1, a, d, 5'h01, 1'b1);
   endtask

   initial
   begin
      rd           = 1'b0;
      wr           = 1'b0;
      stall        = 1'b0;
      addr         = '0;
      dataIn       = '0;
      hitC0        = 1'b0;
      hitC1        = 1'b0;
      validC0      = 1'b0;
      validC1      = 1'b0;
      dirtyC0      = 1'b0;
      dirtyC1      = 1'b0;
      victimWay    = 1'b0;
      tagC0        = '0;
      tagC1        = '0;
      memDataOut   = '0;
      memPipeValid = 1'b0;
      memPipeAddr  = '0;
      cacheBase    = '0;
      lcgState     = 32'h6efc8b24;
      testName     = "reset";
      wait (arstN === 1'b1);
      resetIdleTest();
      hitTest();
      cleanMissTest();
      dirtyMissTest();
      captureTest();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* sim/tbClock.sv */
module tbClock (
   output logic clk,
   output logic arstN
);
   timeunit 1ns;
   timeprecision 1ps;

   // 8 ns period
   localparam int halfPeriod = 4;
   localparam int resetCycles = 4;

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #halfPeriod clk = ~clk;
      end
   end

   // reset held low for four cycles, released on a rising edge
   initial
   begin
      arstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      arstN <= 1'b1;
   end

endmodule

/* source/cacheCtlTop.sv */
module cacheCtlTop (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  rd,
   input  logic                  wr,
   input  logic                  stall,
   input  cacheCtlPkg::addrT     addr,
   input  cacheCtlPkg::dataT     dataIn,
   input  logic                  hitC0,
   input  logic                  hitC1,
   input  logic                  validC0,
   input  logic                  validC1,
   input  logic                  dirtyC0,
   input  logic                  dirtyC1,
   input  logic                  victimWay,
   input  cacheCtlPkg::tagT      tagC0,
   input  cacheCtlPkg::tagT      tagC1,
   input  cacheCtlPkg::dataT     cacheDataOut,
   input  cacheCtlPkg::dataT     memDataOut,
   output cacheCtlPkg::dataT     fsmDataOut,
   output cacheCtlPkg::addrT     addrOut,
   output cacheCtlPkg::wordIdxT  wordOut,
   output logic                  done,
   output logic                  stallOut,
   output logic                  cacheWrite0,
   output logic                  cacheWrite1,
   output logic                  memWrite,
   output logic                  memRead,
   output logic                  comp0,
   output logic                  comp1,
   output logic                  enC0,
   output logic                  enC1
);

   // sequence phase shared by the input and output sides
   cacheCtlPkg::phaseT phase;

   reqIf req ();

   // classify, choose the way, hold the request
   reqDecode reqDecode_i (
      .clk       (clk),
      .arstN     (arstN),
      .rd        (rd),
      .wr        (wr),
      .stall     (stall),
      .addr      (addr),
      .dataIn    (dataIn),
      .hitC0     (hitC0),
      .hitC1     (hitC1),
      .validC0   (validC0),
      .validC1   (validC1),
      .dirtyC0   (dirtyC0),
      .dirtyC1   (dirtyC1),
      .victimWay (victimWay),
      .phase     (phase),
      .req       (req.decode)
   );

   fillSequencer fillSequencer_i (
      .clk   (clk),
      .arstN (arstN),
      .req   (req.seq),
      .phase (phase)
   );

   // all cache and memory commands
   cmdDrive cmdDrive_i (
      .phase        (phase),
      .req          (req.drive),
      .tagC0        (tagC0),
      .tagC1        (tagC1),
      .cacheDataOut (cacheDataOut),
      .memDataOut   (memDataOut),
      .fsmDataOut   (fsmDataOut),
      .addrOut      (addrOut),
      .wordOut      (wordOut),
      .done         (done),
      .stallOut     (stallOut),
      .cacheWrite0  (cacheWrite0),
      .cacheWrite1  (cacheWrite1),
      .memWrite     (memWrite),
      .memRead      (memRead),
      .comp0        (comp0),
      .comp1        (comp1),
      .enC0         (enC0),
      .enC1         (enC1)
   );

endmodule

/* source/cmdDrive.sv */
`include "cacheCtl_cfg.svh"

module cmdDrive (
   input  cacheCtlPkg::phaseT    phase,
   reqIf.drive                   req,
   input  cacheCtlPkg::tagT      tagC0,
   input  cacheCtlPkg::tagT      tagC1,
   input  cacheCtlPkg::dataT     cacheDataOut,
   input  cacheCtlPkg::dataT     memDataOut,
   output cacheCtlPkg::dataT     fsmDataOut,
   output cacheCtlPkg::addrT     addrOut,
   output cacheCtlPkg::wordIdxT  wordOut,
   output logic                  done,
   output logic                  stallOut,
   output logic                  cacheWrite0,
   output logic                  cacheWrite1,
   output logic                  memWrite,
   output logic                  memRead,
   output logic                  comp0,
   output logic                  comp1,
   output logic                  enC0,
   output logic                  enC1
);

   // captured way steers every non-idle cache command
   logic sel0;
   logic sel1;

   // tag of the line being evicted
   cacheCtlPkg::tagT victimTag;

   // memory side word and cache side word of the current phase
   cacheCtlPkg::wordIdxT memWord;
   cacheCtlPkg::wordIdxT cacheWord;

   // word field of the held request
   cacheCtlPkg::wordIdxT reqWord;

   assign sel0      = ~req.wayQ;
   assign sel1      = req.wayQ;
   assign victimTag = req.wayQ ? tagC1 : tagC0;
   assign reqWord   = req.addrQ[`WORD_LSB +: `WORD_W];

   // processor sees a stall for the whole sequence
   assign stallOut = (phase != cacheCtlPkg::phIdle);

   // fill writes trail the matching reads by the two cycle memory latency
   always_comb
   begin
      memWord   = '0;
      cacheWord = '0;
      case (phase)
         cacheCtlPkg::phWback1, cacheCtlPkg::phFill1: memWord = cacheCtlPkg::wordIdxT'(1);
         cacheCtlPkg::phWback2, cacheCtlPkg::phFill2: memWord = cacheCtlPkg::wordIdxT'(2);
         cacheCtlPkg::phWback3, cacheCtlPkg::phFill3: memWord = cacheCtlPkg::wordIdxT'(3);
         default: memWord = '0;
      endcase
      case (phase)
         cacheCtlPkg::phWback1, cacheCtlPkg::phFill3: cacheWord = cacheCtlPkg::wordIdxT'(1);
         cacheCtlPkg::phWback2, cacheCtlPkg::phFill4: cacheWord = cacheCtlPkg::wordIdxT'(2);
         cacheCtlPkg::phWback3, cacheCtlPkg::phFill5: cacheWord = cacheCtlPkg::wordIdxT'(3);
         default: cacheWord = '0;
      endcase
   end

   always_comb
   begin
      fsmDataOut  = '0;
      addrOut     = req.addrQ;
      wordOut     = reqWord;
      done        = 1'b0;
      cacheWrite0 = 1'b0;
      cacheWrite1 = 1'b0;
      memWrite    = 1'b0;
      memRead     = 1'b0;
      comp0       = 1'b0;
      comp1       = 1'b0;
      enC0        = 1'b0;
      enC1        = 1'b0;
      case (phase)
         cacheCtlPkg::phIdle:
         begin
            // both ways look up the tag, a hit completes right here
            enC0        = req.reqValid;
            enC1        = req.reqValid;
            comp0       = req.reqValid;
            comp1       = req.reqValid;
            done        = req.reqValid & req.hit;
            cacheWrite0 = req.reqValid & req.hit & req.isWrite & ~req.hitWay;
            cacheWrite1 = req.reqValid & req.hit & req.isWrite & req.hitWay;
            if (req.reqValid && req.isWrite)
            begin
               fsmDataOut = req.dataQ;
            end
         end
         cacheCtlPkg::phWback0, cacheCtlPkg::phWback1,
         cacheCtlPkg::phWback2, cacheCtlPkg::phWback3:
         begin
            // victim word read from the cache goes to its own bank
            enC0       = sel0;
            enC1       = sel1;
            memWrite   = 1'b1;
            fsmDataOut = cacheDataOut;
            addrOut    = {victimTag, req.addrQ[`INDEX_MSB:`INDEX_LSB], memWord, 1'b0};
            wordOut    = cacheWord;
         end
         cacheCtlPkg::phFill0, cacheCtlPkg::phFill1:
         begin
            // reads issued, nothing back from memory yet
            enC0    = sel0;
            enC1    = sel1;
            memRead = 1'b1;
            addrOut = {req.addrQ[`ADDR_W-1:`INDEX_LSB], memWord, 1'b0};
         end
         cacheCtlPkg::phFill2, cacheCtlPkg::phFill3:
         begin
            // last two reads overlap with the first two returns
            enC0        = sel0;
            enC1        = sel1;
            memRead     = 1'b1;
            cacheWrite0 = sel0;
            cacheWrite1 = sel1;
            fsmDataOut  = memDataOut;
            addrOut     = {req.addrQ[`ADDR_W-1:`INDEX_LSB], memWord, 1'b0};
            wordOut     = cacheWord;
         end
         cacheCtlPkg::phFill4, cacheCtlPkg::phFill5:
         begin
            // only returns left to drain into the way
            enC0        = sel0;
            enC1        = sel1;
            cacheWrite0 = sel0;
            cacheWrite1 = sel1;
            fsmDataOut  = memDataOut;
            wordOut     = cacheWord;
         end
         cacheCtlPkg::phCacheRw:
         begin
            // the original access, now a hit on the filled way
            enC0        = sel0;
            enC1        = sel1;
            comp0       = sel0;
            comp1       = sel1;
            cacheWrite0 = sel0 & req.writeQ;
            cacheWrite1 = sel1 & req.writeQ;
            if (req.writeQ)
            begin
               fsmDataOut = req.dataQ;
            end
         end
         cacheCtlPkg::phDone:
         begin
            // keep a read way enabled so its data is still on the bus
            done = 1'b1;
            enC0 = sel0 & ~req.writeQ;
            enC1 = sel1 & ~req.writeQ;
         end
         default:
         begin
            addrOut = '0;
         end
      endcase
   end

endmodule

/* source/fillSequencer.sv */
module fillSequencer (
   input  logic                clk,
   input  logic                arstN,
   reqIf.seq                   req,
   output cacheCtlPkg::phaseT  phase
);

   cacheCtlPkg::phaseT phaseNext;

   // leaves idle only on a miss, every other phase steps on unconditionally
   always_comb
   begin
      phaseNext = cacheCtlPkg::phIdle;
      case (phase)
         cacheCtlPkg::phIdle:
         begin
            // hits finish in idle
            if (req.reqValid && !req.hit)
            begin
               if (req.needWriteback)
               begin
                  phaseNext = cacheCtlPkg::phWback0;
               end
               else
               begin
                  phaseNext = cacheCtlPkg::phFill0;
               end
            end
         end
         // victim line out, one word per cycle
         cacheCtlPkg::phWback0:
         begin
            phaseNext = cacheCtlPkg::phWback1;
         end
         cacheCtlPkg::phWback1:
         begin
            phaseNext = cacheCtlPkg::phWback2;
         end
         cacheCtlPkg::phWback2:
         begin
            phaseNext = cacheCtlPkg::phWback3;
         end
         cacheCtlPkg::phWback3:
         begin
            phaseNext = cacheCtlPkg::phFill0;
         end
         // new line in, reads lead the cache writes by two cycles
         cacheCtlPkg::phFill0:
         begin
            phaseNext = cacheCtlPkg::phFill1;
         end
         cacheCtlPkg::phFill1:
         begin
            phaseNext = cacheCtlPkg::phFill2;
         end
         cacheCtlPkg::phFill2:
         begin
            phaseNext = cacheCtlPkg::phFill3;
         end
         cacheCtlPkg::phFill3:
         begin
            phaseNext = cacheCtlPkg::phFill4;
         end
         cacheCtlPkg::phFill4:
         begin
            phaseNext = cacheCtlPkg::phFill5;
         end
         cacheCtlPkg::phFill5:
         begin
            phaseNext = cacheCtlPkg::phCacheRw;
         end
         // replay the original access on the filled line
         cacheCtlPkg::phCacheRw:
         begin
            phaseNext = cacheCtlPkg::phDone;
         end
         // done phase falls through to idle via the default
         default:
         begin
            phaseNext = cacheCtlPkg::phIdle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         phase <= cacheCtlPkg::phIdle;
      end
      else
      begin
         phase <= phaseNext;
      end
   end

endmodule

/* source/reqDecode.sv */
module reqDecode (
   input  logic                clk,
   input  logic                arstN,
   input  logic                rd,
   input  logic                wr,
   input  logic                stall,
   input  cacheCtlPkg::addrT   addr,
   input  cacheCtlPkg::dataT   dataIn,
   input  logic                hitC0,
   input  logic                hitC1,
   input  logic                validC0,
   input  logic                validC1,
   input  logic                dirtyC0,
   input  logic                dirtyC1,
   input  logic                victimWay,
   input  cacheCtlPkg::phaseT  phase,
   reqIf.decode                req
);

   // a hit only counts on a valid line
   logic hitValid0;
   logic hitValid1;

   // way the miss will replace
   logic fillWay;

   // capture happens in every idle cycle
   logic isIdle;

   // held copies of the request
   cacheCtlPkg::addrT addrReg;
   cacheCtlPkg::dataT dataReg;
   logic              wayReg;
   logic              writeReg;

   assign isIdle    = (phase == cacheCtlPkg::phIdle);
   assign hitValid0 = hitC0 & validC0;
   assign hitValid1 = hitC1 & validC1;

   // exactly one of rd or wr, not stalled, and no sequence running
   assign req.reqValid = (rd ^ wr) & ~stall & isIdle;
   assign req.isWrite  = wr;
   assign req.hit      = hitValid0 | hitValid1;

   // way 0 wins when both report a hit
   assign req.hitWay = hitValid0 ? 1'b0 : 1'b1;

   // prefer an empty way, otherwise the replacement pick
   always_comb
   begin
      if (!validC0)
      begin
         fillWay = 1'b0;
      end
      else if (!validC1)
      begin
         fillWay = 1'b1;
      end
      else
      begin
         fillWay = victimWay;
      end
   end

   // only a valid dirty victim must go back to memory first
   assign req.needWriteback = fillWay ? (validC1 & dirtyC1) : (validC0 & dirtyC0);

   // way and operation, reset to a known read of way 0
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         wayReg   <= 1'b0;
         writeReg <= 1'b0;
      end
      else if (isIdle)
      begin
         wayReg   <= fillWay;
         writeReg <= wr;
      end
   end

   // address and data, frozen once the sequence leaves idle
   always_ff @(posedge clk)
   begin
      if (isIdle)
      begin
         addrReg <= addr;
         dataReg <= dataIn;
      end
   end

   // in idle the live request passes straight through for the same-cycle hit path
   assign req.addrQ = isIdle ? addr : addrReg;
   assign req.dataQ = isIdle ? dataIn : dataReg;

   assign req.wayQ   = wayReg;
   assign req.writeQ = writeReg;

endmodule

/* source/reqIf.sv */
interface reqIf;

   // live classification of the request seen this cycle
   logic reqValid;
   logic isWrite;
   logic hit;
   logic hitWay;
   logic needWriteback;

   // request as held for the miss sequence
   cacheCtlPkg::addrT addrQ;
   cacheCtlPkg::dataT dataQ;
   logic wayQ;
   logic writeQ;

   // input side produces everything
   modport decode (
      output reqValid, isWrite, hit, hitWay, needWriteback,
      output addrQ, dataQ, wayQ, writeQ
   );

   // phase register only needs to know how to leave idle
   modport seq (
      input reqValid, hit, needWriteback
   );

   // command decode
   modport drive (
      input reqValid, isWrite, hit, hitWay,
      input addrQ, dataQ, wayQ, writeQ
   );

endinterface

/* source/cacheCtlPkg.sv */
`include "cacheCtl_cfg.svh"

package cacheCtlPkg;

   // processor byte address
   typedef logic [`ADDR_W-1:0] addrT;

   // one data word, also one memory bank word
   typedef logic [`DATA_W-1:0] dataT;

   // tag as stored in each way
   typedef logic [`TAG_W-1:0] tagT;

   // word number inside a line
   typedef logic [`WORD_W-1:0] wordIdxT;

   // miss sequence phases
   // wback phases copy the dirty victim line out to memory
   // fill phases read the new line in, two phases of overlap with the memory latency
   typedef enum logic [3:0] {
      phIdle,
      phWback0,
      phWback1,
      phWback2,
      phWback3,
      phFill0,
      phFill1,
      phFill2,
      phFill3,
      phFill4,
      phFill5,
      phCacheRw,
      phDone
   } phaseT;

endpackage

/* include/cacheCtl_cfg.svh */
`ifndef CACHECTL_CFG_SVH
`define CACHECTL_CFG_SVH

// byte address and data word widths
`define ADDR_W 16
`define DATA_W 16

// tag sits in the top address bits, 15 down to 11
`define TAG_W 5

// set index field, bits 3 to 10
`define INDEX_LSB 3
`define INDEX_MSB 10

// word within a line starts above the byte bit
`define WORD_LSB 1

// one line is one word per memory bank
`define WORDS_PER_LINE 4

// width of the word-in-line field
`define WORD_W $clog2(`WORDS_PER_LINE)

`endif
